//--- Bender.yml
package:
  name: board_io

sources:
  # Design, package first
  - hw/board_io_pkg.sv
  - hw/reset_ctrl.sv
  - hw/gpio_regs.sv
  - hw/gpio_pad.sv
  - hw/gpio_event.sv
  - hw/board_io_top.sv

  # Testbench, top module board_io_tb
  - target: simulation
    files:
      - verif/board_io_chk.sv
      - verif/clk_gen.sv
      - verif/board_io_tb.sv

//--- board_io.f
hw/board_io_pkg.sv
hw/reset_ctrl.sv
hw/gpio_regs.sv
hw/gpio_pad.sv
hw/gpio_event.sv
hw/board_io_top.sv
verif/board_io_chk.sv
verif/clk_gen.sv
verif/board_io_tb.sv

//--- hw/board_io_pkg.sv
package board_io_pkg;

  // GPIO bank size
  localparam int GPIO_W = 12;

  // Register port widths
  localparam int ADDR_W = 3;
  localparam int DATA_W = 16;

  typedef logic [GPIO_W-1:0] gpio_vec_t;
  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0] reg_data_t;

  // Register map
  localparam reg_addr_t ADDR_DIR  = 3'd0;
  localparam reg_addr_t ADDR_OUT  = 3'd1;
  localparam reg_addr_t ADDR_IN   = 3'd2;
  localparam reg_addr_t ADDR_PEND = 3'd3;
  localparam reg_addr_t ADDR_MASK = 3'd4;

  // Cycles of stable lock before the system reset is released
  localparam int RST_HOLD_CYCLES = 16;

  typedef logic [4:0] rst_cnt_t;

  // Sequencer states
  typedef enum logic [1:0] {
    RST_WAIT_LOCK = 2'd0,
    RST_HOLD      = 2'd1,
    RST_RUN       = 2'd2
  } rst_state_t;

endpackage

//--- hw/board_io_top.sv
`timescale 1ns/1ps

module board_io_top
  import board_io_pkg::*;
(
  input  logic      i_clk,
  // Power-on reset, active low
  input  logic      i_arst_n,
  input  logic      i_pll_locked,
  input  logic      i_dbg_reset_req,
  // Register port
  input  logic      i_wr,
  input  logic      i_rd,
  input  reg_addr_t i_addr,
  input  reg_data_t i_wdata,
  output reg_data_t o_rdata,
  output logic      o_rvalid,
  output logic      o_irq,
  // Reset status
  output logic      o_sys_ready,
  output logic      o_dbg_nrst,
  // Pins
  inout  wire [GPIO_W-1:0] io_gpio
);

  logic      w_sys_nrst;
  gpio_vec_t w_dir;
  gpio_vec_t w_out;
  gpio_vec_t w_mask;
  gpio_vec_t w_clr;
  gpio_vec_t w_pad_in;
  gpio_vec_t w_in;
  gpio_vec_t w_pend;

  reset_ctrl rst0 (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_pll_locked    (i_pll_locked),
    .i_dbg_reset_req (i_dbg_reset_req),
    .o_sys_nrst      (w_sys_nrst),
    .o_dbg_nrst      (o_dbg_nrst)
  );

  assign o_sys_ready = w_sys_nrst;

  // Everything below runs on the system reset
  gpio_regs regs0 (
    .i_clk    (i_clk),
    .i_arst_n (w_sys_nrst),
    .i_wr     (i_wr),
    .i_rd     (i_rd),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .i_in     (w_in),
    .i_pend   (w_pend),
    .o_dir    (w_dir),
    .o_out    (w_out),
    .o_mask   (w_mask),
    .o_clr    (w_clr),
    .o_rdata  (o_rdata),
    .o_rvalid (o_rvalid)
  );

  genvar i;
  generate
    for (i = 0; i < GPIO_W; i++) begin : gpiox
      gpio_pad iob0 (
        .i_clk    (i_clk),
        .i_arst_n (w_sys_nrst),
        .i_dir    (w_dir[i]),
        .i_out    (w_out[i]),
        .o_in     (w_pad_in[i]),
        .io_pin   (io_gpio[i])
      );
    end
  endgenerate

  gpio_event evt0 (
    .i_clk    (i_clk),
    .i_arst_n (w_sys_nrst),
    .i_in     (w_pad_in),
    .i_clr    (w_clr),
    .i_mask   (w_mask),
    .o_in     (w_in),
    .o_pend   (w_pend),
    .o_irq    (o_irq)
  );

endmodule

//--- hw/gpio_event.sv
`timescale 1ns/1ps

module gpio_event
  import board_io_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  input  gpio_vec_t i_in,
  input  gpio_vec_t i_clr,
  input  gpio_vec_t i_mask,
  output gpio_vec_t o_in,
  output gpio_vec_t o_pend,
  output logic      o_irq
);

  gpio_vec_t in_q;
  gpio_vec_t prev_q;
  gpio_vec_t rise;
  gpio_vec_t pend_q;
  logic      irq_q;

  // Collector register and the previous sample
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_q   <= '0;
      prev_q <= '0;
    end else begin
      in_q   <= i_in;
      prev_q <= in_q;
    end
  end

  assign rise = in_q & ~prev_q;

  // Set wins over a clear of the same bit
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~i_clr) | rise;
    end
  end

  // Interrupt lags pending by one cycle
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= |(pend_q & i_mask);
    end
  end

  assign o_in   = in_q;
  assign o_pend = pend_q;
  assign o_irq  = irq_q;

endmodule

//--- hw/gpio_pad.sv
`timescale 1ns/1ps

module gpio_pad (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_dir,
  input  logic i_out,
  output logic o_in,
  inout  wire  io_pin
);

  logic       out_q;
  logic [1:0] in_sync;

  // Pad copy of the OUT bit
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_q <= 1'b0;
    end else begin
      out_q <= i_out;
    end
  end

  // Direction is not delayed, so the pin is released as soon as DIR clears
  assign io_pin = i_dir ? out_q : 1'bz;

  // Pin level is asynchronous to i_clk
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_sync <= '0;
    end else begin
      in_sync <= {in_sync[0], io_pin};
    end
  end

  assign o_in = in_sync[1];

endmodule

//--- hw/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs
  import board_io_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  // Register port
  input  logic      i_wr,
  input  logic      i_rd,
  input  reg_addr_t i_addr,
  input  reg_data_t i_wdata,
  // Status from the event collector
  input  gpio_vec_t i_in,
  input  gpio_vec_t i_pend,
  // Controls to pads and collector
  output gpio_vec_t o_dir,
  output gpio_vec_t o_out,
  output gpio_vec_t o_mask,
  output gpio_vec_t o_clr,
  // Read return
  output reg_data_t o_rdata,
  output logic      o_rvalid
);

  gpio_vec_t dir_q;
  gpio_vec_t out_q;
  gpio_vec_t mask_q;
  gpio_vec_t wr_bits;
  reg_data_t rd_mux;
  reg_data_t rdata_q;
  logic      rvalid_q;

  // Only the pin bits of a write are stored
  assign wr_bits = i_wdata[GPIO_W-1:0];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dir_q  <= '0;
      out_q  <= '0;
      mask_q <= '0;
    end else if (i_wr) begin
      case (i_addr)
        ADDR_DIR:  dir_q  <= wr_bits;
        ADDR_OUT:  out_q  <= wr_bits;
        ADDR_MASK: mask_q <= wr_bits;
        default: begin
          // IN is read only, PEND is handled by the collector
        end
      endcase
    end
  end

  // Write-1-clear strobe, one cycle wide because i_wr is
  assign o_clr = (i_wr && (i_addr == ADDR_PEND)) ? wr_bits : '0;

  always_comb begin
    case (i_addr)
      ADDR_DIR:  rd_mux = reg_data_t'(dir_q);
      ADDR_OUT:  rd_mux = reg_data_t'(out_q);
      ADDR_IN:   rd_mux = reg_data_t'(i_in);
      ADDR_PEND: rd_mux = reg_data_t'(i_pend);
      ADDR_MASK: rd_mux = reg_data_t'(mask_q);
      default:   rd_mux = '0;
    endcase
  end

  // Read data is captured on the strobe and held
  always_ff @(posedge i_clk) begin
    if (i_rd) begin
      rdata_q <= rd_mux;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= i_rd;
    end
  end

  assign o_dir    = dir_q;
  assign o_out    = out_q;
  assign o_mask   = mask_q;
  assign o_rdata  = rdata_q;
  assign o_rvalid = rvalid_q;

endmodule

//--- hw/reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl
  import board_io_pkg::*;
(
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_pll_locked,
  input  logic i_dbg_reset_req,
  output logic o_sys_nrst,
  output logic o_dbg_nrst
);

  localparam rst_cnt_t HOLD_LAST = rst_cnt_t'(RST_HOLD_CYCLES - 1);

  logic [1:0] dbg_rst_sync;
  logic [1:0] lock_sync;
  logic [1:0] req_sync;
  logic       run_ok;
  rst_state_t state_q;
  rst_state_t state_d;
  rst_cnt_t   cnt_q;
  rst_cnt_t   cnt_d;
  logic       sys_nrst_q;

  // Debug reset follows only the power-on reset
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dbg_rst_sync <= '0;
    end else begin
      dbg_rst_sync <= {dbg_rst_sync[0], 1'b1};
    end
  end

  // Lock and request come from other domains
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      lock_sync <= '0;
      req_sync  <= '0;
    end else begin
      lock_sync <= {lock_sync[0], i_pll_locked};
      req_sync  <= {req_sync[0], i_dbg_reset_req};
    end
  end

  assign run_ok = lock_sync[1] & ~req_sync[1];

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      RST_WAIT_LOCK: begin
        cnt_d = '0;
        if (run_ok) begin
          state_d = RST_HOLD;
        end
      end
      RST_HOLD: begin
        if (!run_ok) begin
          // Lock lost or debug request, count starts over
          state_d = RST_WAIT_LOCK;
          cnt_d   = '0;
        end else if (cnt_q == HOLD_LAST) begin
          state_d = RST_RUN;
          cnt_d   = '0;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      RST_RUN: begin
        if (!run_ok) begin
          state_d = RST_WAIT_LOCK;
        end
      end
      default: state_d = RST_WAIT_LOCK;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= RST_WAIT_LOCK;
      cnt_q      <= '0;
      sys_nrst_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      cnt_q      <= cnt_d;
      // Registered so the reset net is glitch free
      sys_nrst_q <= (state_d == RST_RUN);
    end
  end

  assign o_sys_nrst = sys_nrst_q;
  assign o_dbg_nrst = dbg_rst_sync[1];

endmodule

//--- verif/board_io_chk.sv
`timescale 1ns/1ps

module board_io_chk
  import board_io_pkg::*;
(
  input logic      i_clk,
  input logic      i_sys_nrst,
  input logic      i_rd,
  input logic      i_rvalid,
  input gpio_vec_t i_dir,
  input gpio_vec_t i_pin,
  input gpio_vec_t i_pend,
  input gpio_vec_t i_mask,
  input logic      i_irq
);

  // Read data valid one cycle after the strobe, and never otherwise
  a_rvalid: assert property (@(posedge i_clk) disable iff (!i_sys_nrst)
    i_rvalid == $past(i_rd))
    else $error("read valid is not a one-cycle echo of the read strobe");

  // An input pin carries only the external level, so a clash would show as X
  genvar i;
  generate
    for (i = 0; i < GPIO_W; i++) begin : pinx
      a_released: assert property (@(posedge i_clk) disable iff (!i_sys_nrst)
        !i_dir[i] |-> (i_pin[i] !== 1'bx))
        else $error("pin %0d is driven by the DUT while configured as input", i);
    end
  endgenerate

  // Registered interrupt, one cycle behind pending and mask
  a_irq: assert property (@(posedge i_clk) disable iff (!i_sys_nrst)
    i_irq == $past(|(i_pend & i_mask)))
    else $error("interrupt does not match the enabled pending bits");

endmodule

//--- verif/board_io_tb.sv
`timescale 1ns/1ps

module board_io_tb
  import board_io_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  // Rough length of the six tests in cycles
  localparam int TEST_CYCLES = 60 + 160 + 180 + 80 + 80 + 150;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 2000;

  logic             clk;
  logic             arst_n;
  logic             pll_locked;
  logic             dbg_reset_req;
  logic             wr;
  logic             rd;
  reg_addr_t        addr;
  reg_data_t        wdata;
  reg_data_t        rdata;
  logic             rvalid;
  logic             irq;
  logic             sys_ready;
  logic             dbg_nrst;
  wire [GPIO_W-1:0] gpio;

  // Expected register and pin state
  gpio_vec_t exp_dir;
  gpio_vec_t exp_out;
  gpio_vec_t exp_mask;
  gpio_vec_t exp_pend;
  gpio_vec_t exp_lvl;
  gpio_vec_t pin_drv;
  reg_data_t exp_q[$];
  reg_data_t exp_rdata;

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     test_start_errors;
  int     cycles;

  clk_gen clk0 (.o_clk(clk), .o_arst_n(arst_n));

  board_io_top DUT (
    .i_clk (clk), .i_arst_n (arst_n), .i_pll_locked (pll_locked),
    .i_dbg_reset_req (dbg_reset_req), .i_wr (wr), .i_rd (rd), .i_addr (addr),
    .i_wdata (wdata), .o_rdata (rdata), .o_rvalid (rvalid), .o_irq (irq),
    .o_sys_ready (sys_ready), .o_dbg_nrst (dbg_nrst), .io_gpio (gpio)
  );

  bind board_io_top board_io_chk chk0 (
    .i_clk (i_clk), .i_sys_nrst (w_sys_nrst), .i_rd (i_rd), .i_rvalid (o_rvalid),
    .i_dir (w_dir), .i_pin (io_gpio), .i_pend (w_pend), .i_mask (w_mask), .i_irq (o_irq)
  );

  // Pin model, drives only pins that should be inputs
  genvar g;
  generate
    for (g = 0; g < GPIO_W; g++) begin : pinx
      assign gpio[g] = exp_dir[g] ? 1'bz : pin_drv[g];
    end
  endgenerate

  function automatic reg_data_t expect_read(input reg_addr_t a, input gpio_vec_t dir,
      input gpio_vec_t out, input gpio_vec_t in, input gpio_vec_t pend,
      input gpio_vec_t mask);
    reg_data_t d;
    d = '0;
    case (a)
      ADDR_DIR:  d[GPIO_W-1:0] = dir;
      ADDR_OUT:  d[GPIO_W-1:0] = out;
      ADDR_IN:   d[GPIO_W-1:0] = in;
      ADDR_PEND: d[GPIO_W-1:0] = pend;
      ADDR_MASK: d[GPIO_W-1:0] = mask;
      default:   d = '0;
    endcase
    return d;
  endfunction

  function automatic reg_data_t rand_word();
    return reg_data_t'($random(seed));
  endfunction

  // Every new pin level is seen by the synchronizers, so 0 to 1 sets pending
  function automatic void track_pin_level();
    gpio_vec_t nxt;
    nxt      = (exp_dir & exp_out) | (~exp_dir & pin_drv);
    exp_pend = exp_pend | (nxt & ~exp_lvl);
    exp_lvl  = nxt;
  endfunction

  // System reset clears the bank, then the pins come back as fresh edges
  function automatic void reset_model();
    exp_dir  = '0;
    exp_out  = '0;
    exp_mask = '0;
    exp_pend = '0;
    exp_lvl  = '0;
    track_pin_level();
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check_equal(input string name, input reg_data_t exp_v,
      input reg_data_t act_v);
    checks++;
    assert (act_v === exp_v) else begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic set_drive(input gpio_vec_t v);
    pin_drv = v;
    track_pin_level();
    wait_cycles(1);
  endtask

  // Idle cycle after each write keeps pin level changes apart
  task automatic write_reg(input reg_addr_t a, input reg_data_t d);
    wr    = 1'b1;
    addr  = a;
    wdata = d;
    wait_cycles(1);
    wr = 1'b0;
    case (a)
      ADDR_DIR:  exp_dir  = d[GPIO_W-1:0];
      ADDR_OUT:  exp_out  = d[GPIO_W-1:0];
      ADDR_MASK: exp_mask = d[GPIO_W-1:0];
      ADDR_PEND: exp_pend = exp_pend & ~d[GPIO_W-1:0];
      default: begin
      end
    endcase
    track_pin_level();
    wait_cycles(1);
  endtask

  task automatic read_reg(input reg_addr_t a);
    rd   = 1'b1;
    addr = a;
    exp_q.push_back(expect_read(a, exp_dir, exp_out, exp_lvl, exp_pend, exp_mask));
    wait_cycles(1);
    rd = 1'b0;
    wait_cycles(1);
  endtask

  task automatic drain_reads();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 10) begin
      wait_cycles(1);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%0d read responses never arrived", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic wait_ready_level(input logic level, input int limit, output int n);
    n = 0;
    while (sys_ready !== level && n < limit) begin
      wait_cycles(1);
      n++;
    end
    assert (sys_ready === level) else begin
      $display("o_sys_ready never became %0b within %0d cycles", level, limit);
      errors++;
    end
  endtask

  task automatic reenter_reset(input bit drop_lock);
    int n;
    write_reg(ADDR_DIR, rand_word());
    write_reg(ADDR_OUT, rand_word());
    write_reg(ADDR_MASK, rand_word() | 16'h0001);
    wait_cycles(6);
    if (drop_lock) begin
      pll_locked = 1'b0;
    end else begin
      dbg_reset_req = 1'b1;
    end
    wait_ready_level(1'b0, 10, n);
    checks++;
    assert (n <= 3) else begin
      $display("system reset took %0d cycles to assert, more than 3", n);
      errors++;
    end
    check_equal("o_dbg_nrst", 1, dbg_nrst);
    reset_model();
    wait_cycles(5);
    pll_locked    = 1'b1;
    dbg_reset_req = 1'b0;
    wait_ready_level(1'b1, 40, n);
    wait_cycles(6);
    read_reg(ADDR_DIR);
    read_reg(ADDR_OUT);
    read_reg(ADDR_MASK);
    read_reg(ADDR_IN);
    read_reg(ADDR_PEND);
    drain_reads();
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d mismatches", tests, name,
      errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // Compare process, samples in the middle of the valid cycle
  always @(negedge clk) begin
    if (rvalid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("read data returned at t=%0t with no read outstanding", $time);
        errors++;
      end else begin
        exp_rdata = exp_q.pop_front();
        checks++;
        assert (rdata === exp_rdata) else begin
          $display("ERROR t=%0t o_rdata expected %h actual %h", $time, exp_rdata, rdata);
          errors++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    seed          = 32'h91e3_9ebd;
    pll_locked    = 1'b0;
    dbg_reset_req = 1'b0;
    wr            = 1'b0;
    rd            = 1'b0;
    addr          = '0;
    wdata         = '0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    test_start_errors = 0;
    pin_drv       = gpio_vec_t'($random(seed));
    reset_model();

    @(posedge arst_n);
    cycles = 0;
    while (dbg_nrst !== 1'b1 && cycles < 10) begin
      wait_cycles(1);
      cycles++;
    end
    check_equal("o_dbg_nrst", 1, dbg_nrst);
    repeat (30) begin
      wait_cycles(1);
      check_equal("o_sys_ready", 0, sys_ready);
    end
    pll_locked = 1'b1;
    wait_ready_level(1'b1, 40, cycles);
    checks++;
    assert (cycles >= RST_HOLD_CYCLES + 1 && cycles <= RST_HOLD_CYCLES + 4) else begin
      $display("o_sys_ready rose %0d cycles after lock, outside 17 to 20", cycles);
      errors++;
    end
    finish_test("reset bring-up");

    reenter_reset(1'b0);
    reenter_reset(1'b1);
    finish_test("reset re-entry");

    // Writes to IN and unused addresses must be ignored
    repeat (4) begin
      write_reg(ADDR_DIR, rand_word());
      write_reg(ADDR_OUT, rand_word());
      write_reg(ADDR_MASK, rand_word());
      write_reg(ADDR_IN, rand_word());
      write_reg(3'd5, rand_word());
      write_reg(3'd6, rand_word());
      write_reg(3'd7, rand_word());
      wait_cycles(6);
      for (int a = 0; a < 8; a++) begin
        read_reg(reg_addr_t'(a));
      end
      drain_reads();
    end
    finish_test("register read/write");

    repeat (4) begin
      set_drive(gpio_vec_t'(rand_word()));
      write_reg(ADDR_DIR, rand_word());
      write_reg(ADDR_OUT, rand_word());
      wait_cycles(3);
      check_equal("io_gpio", (exp_dir & exp_out) | (~exp_dir & pin_drv), gpio);
      wait_cycles(6);
      read_reg(ADDR_IN);
      drain_reads();
    end
    finish_test("output pins");

    write_reg(ADDR_PEND, 16'hffff);
    repeat (4) begin
      set_drive(gpio_vec_t'(rand_word()));
      wait_cycles(6);
      read_reg(ADDR_IN);
      read_reg(ADDR_PEND);
      drain_reads();
      write_reg(ADDR_PEND, rand_word());
    end
    finish_test("input edges");

    repeat (3) begin
      set_drive('0);
      wait_cycles(6);
      set_drive(gpio_vec_t'(rand_word()));
      wait_cycles(6);
      write_reg(ADDR_MASK, rand_word());
      wait_cycles(3);
      check_equal("o_irq", |(exp_pend & exp_mask), irq);
      write_reg(ADDR_PEND, rand_word());
      wait_cycles(3);
      check_equal("o_irq", |(exp_pend & exp_mask), irq);
      read_reg(ADDR_PEND);
      drain_reads();
      write_reg(ADDR_PEND, 16'hffff);
      wait_cycles(3);
      check_equal("o_irq", |(exp_pend & exp_mask), irq);
    end
    finish_test("interrupt and clear");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic o_clk,
  output logic o_arst_n
);

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // Power-on reset for 3 cycles, released off the edge like other stimulus
  initial begin
    o_arst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    #2 o_arst_n = 1'b1;
  end

endmodule
